// ==== cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// address split: tag | set | byte offset

// upper address bits kept per way
`define CACHE_TAG_WIDTH 27

// eight sets
`define CACHE_SET_WIDTH 3

// word aligned, offset bits ignored by the cache
`define CACHE_OFFSET_WIDTH 2

// one data word per way
`define CACHE_DATA_WIDTH 32

// full byte address
`define CACHE_ADDR_WIDTH (`CACHE_TAG_WIDTH + `CACHE_SET_WIDTH + `CACHE_OFFSET_WIDTH)

`endif

// ==== rtl/cache_lookup_if.sv ====
// one decoded request, decode stage to way array
interface cache_lookup_if;

    import cache_pkg::*;

    // single cycle pulse per accepted request
    logic        start;

    // held stable until the transaction retires
    logic        we;
    cache_tag_t  tag;
    cache_set_t  set;
    cache_word_t wdata;
    cache_addr_t addr;

    modport decode (
        output start,
        output we,
        output tag,
        output set,
        output wdata,
        output addr
    );

    modport array (
        input start,
        input we,
        input tag,
        input set,
        input wdata,
        input addr
    );

endinterface

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    `include "cache_params.svh"

    // byte address as seen on cpu and memory ports
    typedef logic [`CACHE_ADDR_WIDTH-1:0] cache_addr_t;

    // address fields
    typedef logic [`CACHE_TAG_WIDTH-1:0] cache_tag_t;
    typedef logic [`CACHE_SET_WIDTH-1:0] cache_set_t;

    // one data word
    typedef logic [`CACHE_DATA_WIDTH-1:0] cache_word_t;

    // way select, also used as the per-set replacement pointer
    typedef enum logic {
        WAY_0 = 1'b0,
        WAY_1 = 1'b1
    } cache_way_e;

    // way array sequencer
    typedef enum logic [2:0] {
        ARRAY_IDLE    = 3'd0,
        ARRAY_LOOKUP  = 3'd1,
        ARRAY_MEM_REQ = 3'd2,
        ARRAY_MEM_REL = 3'd3,
        ARRAY_RESPOND = 3'd4
    } array_state_e;

endpackage

// ==== rtl/cache_req_decode.sv ====
`include "cache_params.svh"

module cache_req_decode (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   cpu_req_i,
    input  logic                   cpu_we_i,
    input  cache_pkg::cache_addr_t cpu_addr_i,
    input  cache_pkg::cache_word_t cpu_wdata_i,
    input  logic                   retire_i,
    cache_lookup_if.decode         lookup
);

    import cache_pkg::*;

    logic        busy_q;
    logic        accept;
    logic        we_q;
    cache_addr_t addr_q;
    cache_word_t wdata_q;

    // a request is taken only while no transaction is in flight
    assign accept = cpu_req_i && !busy_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (retire_i) begin
            busy_q <= 1'b0;
        end
    end

    // request fields, captured once per transaction
    always_ff @(posedge clk) begin
        if (accept) begin
            we_q    <= cpu_we_i;
            addr_q  <= cpu_addr_i;
            wdata_q <= cpu_wdata_i;
        end
    end

    // start is seen by the array on the same edge the fields are latched
    assign lookup.start = accept;
    assign lookup.we    = we_q;
    assign lookup.addr  = addr_q;
    assign lookup.wdata = wdata_q;

    // field split, offset bits dropped
    assign lookup.tag = addr_q[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
    assign lookup.set = addr_q[`CACHE_OFFSET_WIDTH +: `CACHE_SET_WIDTH];

endmodule

// ==== rtl/cache_resp_path.sv ====
module cache_resp_path (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   cpu_req_i,
    input  logic                   done_i,
    input  logic                   hit_i,
    input  cache_pkg::cache_word_t rdata_i,
    output logic                   cpu_ack_o,
    output logic                   cpu_hit_o,
    output cache_pkg::cache_word_t cpu_rdata_o,
    output logic                   retire_o
);

    import cache_pkg::*;

    logic        ack_q;
    logic        hit_q;
    logic        retire_q;
    cache_word_t rdata_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q    <= 1'b0;
            hit_q    <= 1'b0;
            retire_q <= 1'b0;
        end else begin
            retire_q <= 1'b0;
            if (done_i) begin
                ack_q <= 1'b1;
                hit_q <= hit_i;
            end else if (ack_q && !cpu_req_i) begin
                // release half of the handshake
                ack_q    <= 1'b0;
                retire_q <= 1'b1;
            end
        end
    end

    // result word held while the ack is up
    always_ff @(posedge clk) begin
        if (done_i) begin
            rdata_q <= rdata_i;
        end
    end

    assign cpu_ack_o   = ack_q;
    assign cpu_hit_o   = hit_q;
    assign cpu_rdata_o = rdata_q;
    assign retire_o    = retire_q;

endmodule

// ==== rtl/cache_way_array.sv ====
`include "cache_params.svh"

module cache_way_array (
    input  logic                   clk,
    input  logic                   reset_i,
    cache_lookup_if.array          lookup,
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output cache_pkg::cache_addr_t mem_addr_o,
    output cache_pkg::cache_word_t mem_wdata_o,
    input  logic                   mem_ack_i,
    input  cache_pkg::cache_word_t mem_rdata_i,
    output logic                   done_o,
    output logic                   hit_o,
    output cache_pkg::cache_word_t rdata_o
);

    import cache_pkg::*;

    localparam int NUM_SETS = 1 << `CACHE_SET_WIDTH;

    // per way storage
    logic [NUM_SETS-1:0] valid_q [2];
    cache_tag_t          tag_q   [2][NUM_SETS];
    cache_word_t         data_q  [2][NUM_SETS];

    // way to evict next, one per set
    cache_way_e repl_q [NUM_SETS];

    array_state_e state_q;
    logic         mem_req_q;
    logic         hit_q;
    cache_way_e   hit_way_q;
    cache_word_t  rdata_q;

    logic       hit0;
    logic       hit1;
    logic       lookup_hit;
    cache_way_e hit_way;
    cache_way_e victim;
    logic       mem_done;
    logic       fill_en;
    logic       update_en;

    // both ways compared in parallel
    assign hit0 = valid_q[0][lookup.set] && (tag_q[0][lookup.set] == lookup.tag);
    assign hit1 = valid_q[1][lookup.set] && (tag_q[1][lookup.set] == lookup.tag);

    // exactly one way may match
    assign lookup_hit = hit0 ^ hit1;
    assign hit_way    = hit1 ? WAY_1 : WAY_0;

    // invalid way first, way 0 before way 1, else the replacement pointer
    always_comb begin
        if (!valid_q[0][lookup.set]) begin
            victim = WAY_0;
        end else if (!valid_q[1][lookup.set]) begin
            victim = WAY_1;
        end else begin
            victim = repl_q[lookup.set];
        end
    end

    assign mem_done  = (state_q == ARRAY_MEM_REQ) && mem_ack_i;
    assign fill_en   = mem_done && !lookup.we;
    assign update_en = mem_done && lookup.we && hit_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= ARRAY_IDLE;
            mem_req_q  <= 1'b0;
            hit_q      <= 1'b0;
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            for (int i = 0; i < NUM_SETS; i++) begin
                repl_q[i] <= WAY_0;
            end
        end else begin
            case (state_q)
                ARRAY_IDLE: begin
                    if (lookup.start) begin
                        state_q <= ARRAY_LOOKUP;
                    end
                end
                ARRAY_LOOKUP: begin
                    hit_q <= lookup_hit;
                    // read hits finish here, everything else goes to memory
                    if (!lookup.we && lookup_hit) begin
                        state_q <= ARRAY_RESPOND;
                    end else begin
                        mem_req_q <= 1'b1;
                        state_q   <= ARRAY_MEM_REQ;
                    end
                end
                ARRAY_MEM_REQ: begin
                    if (mem_ack_i) begin
                        mem_req_q <= 1'b0;
                        state_q   <= ARRAY_MEM_REL;
                    end
                    if (fill_en) begin
                        valid_q[victim][lookup.set] <= 1'b1;
                        repl_q[lookup.set] <= (victim == WAY_0) ? WAY_1 : WAY_0;
                    end
                end
                ARRAY_MEM_REL: begin
                    // wait for memory to drop its ack
                    if (!mem_ack_i) begin
                        state_q <= ARRAY_RESPOND;
                    end
                end
                ARRAY_RESPOND: begin
                    state_q <= ARRAY_IDLE;
                end
                default: begin
                    state_q <= ARRAY_IDLE;
                end
            endcase
        end
    end

    // tags, words and the result word
    always_ff @(posedge clk) begin
        if (state_q == ARRAY_LOOKUP) begin
            hit_way_q <= hit_way;
            rdata_q   <= lookup.we ? lookup.wdata : data_q[hit_way][lookup.set];
        end
        if (fill_en) begin
            tag_q[victim][lookup.set]  <= lookup.tag;
            data_q[victim][lookup.set] <= mem_rdata_i;
            rdata_q                    <= mem_rdata_i;
        end
        if (update_en) begin
            data_q[hit_way_q][lookup.set] <= lookup.wdata;
        end
    end

    // word aligned memory address
    assign mem_req_o   = mem_req_q;
    assign mem_we_o    = lookup.we;
    assign mem_addr_o  = {lookup.addr[`CACHE_ADDR_WIDTH-1:`CACHE_OFFSET_WIDTH],
                          {`CACHE_OFFSET_WIDTH{1'b0}}};
    assign mem_wdata_o = lookup.wdata;

    assign done_o  = (state_q == ARRAY_RESPOND);
    assign hit_o   = hit_q;
    assign rdata_o = rdata_q;

endmodule

// ==== rtl/two_way_cache_top.sv ====
module two_way_cache_top (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   cpu_req_i,
    input  logic                   cpu_we_i,
    input  cache_pkg::cache_addr_t cpu_addr_i,
    input  cache_pkg::cache_word_t cpu_wdata_i,
    output logic                   cpu_ack_o,
    output logic                   cpu_hit_o,
    output cache_pkg::cache_word_t cpu_rdata_o,
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output cache_pkg::cache_addr_t mem_addr_o,
    output cache_pkg::cache_word_t mem_wdata_o,
    input  logic                   mem_ack_i,
    input  cache_pkg::cache_word_t mem_rdata_i
);

    import cache_pkg::*;

    // way array to result path
    logic        done;
    logic        hit;
    cache_word_t rdata;

    // result path back to decode
    logic        retire;

    cache_lookup_if lookup_if ();

    cache_req_decode cache_req_decode_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .cpu_req_i   (cpu_req_i),
        .cpu_we_i    (cpu_we_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .retire_i    (retire),
        .lookup      (lookup_if.decode)
    );

    cache_way_array cache_way_array_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .lookup      (lookup_if.array),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .done_o      (done),
        .hit_o       (hit),
        .rdata_o     (rdata)
    );

    cache_resp_path cache_resp_path_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .cpu_req_i   (cpu_req_i),
        .done_i      (done),
        .hit_i       (hit),
        .rdata_i     (rdata),
        .cpu_ack_o   (cpu_ack_o),
        .cpu_hit_o   (cpu_hit_o),
        .cpu_rdata_o (cpu_rdata_o),
        .retire_o    (retire)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_tb -Mdir obj_dir -f two_way_cache.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vcache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi

exit 0

// ==== two_way_cache.f ====
+incdir+.
rtl/cache_pkg.sv
rtl/cache_lookup_if.sv
rtl/cache_req_decode.sv
rtl/cache_way_array.sv
rtl/cache_resp_path.sv
rtl/two_way_cache_top.sv
verification/cache_tb_clock.sv
verification/cache_props.sv
verification/cache_tb.sv

// ==== verification/cache_props.sv ====
// protocol checks on the cache top level ports
module cache_props (
    input logic                   clk,
    input logic                   reset_i,
    input logic                   cpu_req_i,
    input logic                   cpu_ack_o,
    input cache_pkg::cache_word_t cpu_rdata_o,
    input logic                   mem_req_o,
    input logic                   mem_ack_i
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [1:0] mem_txn_cnt;
    logic       mem_req_prev;

    // memory requests seen during one processor transaction
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_txn_cnt  <= 2'd0;
            mem_req_prev <= 1'b0;
        end else begin
            mem_req_prev <= mem_req_o;
            if (!cpu_req_i && !cpu_ack_o) begin
                mem_txn_cnt <= 2'd0;
            end else if (mem_req_o && !mem_req_prev && mem_txn_cnt != 2'd3) begin
                mem_txn_cnt <= mem_txn_cnt + 2'd1;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) reset_i |=> !cpu_ack_o && !mem_req_o)
        else $error("ack or memory request high after reset");

    ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(cpu_ack_o) |-> $past(cpu_req_i))
        else $error("acknowledge rose without a request");

    ack_held: assert property (@(posedge clk) disable iff (reset_i)
        cpu_ack_o && cpu_req_i |=> cpu_ack_o && $stable(cpu_rdata_o))
        else $error("acknowledge or result changed while request held");

    mem_req_held: assert property (@(posedge clk) disable iff (reset_i)
        mem_req_o && !mem_ack_i |=> mem_req_o)
        else $error("memory request dropped before acknowledge");

    single_mem_txn: assert property (@(posedge clk) disable iff (reset_i)
        mem_txn_cnt <= 2'd1)
        else $error("more than one memory transaction per processor request");

endmodule

bind two_way_cache_top cache_props cache_props_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .cpu_req_i   (cpu_req_i),
    .cpu_ack_o   (cpu_ack_o),
    .cpu_rdata_o (cpu_rdata_o),
    .mem_req_o   (mem_req_o),
    .mem_ack_i   (mem_ack_i)
);

// ==== verification/cache_tb.sv ====
module cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam cache_word_t MEM_PATTERN    = 32'h5a5a_c3c3;

    logic        clk;
    logic        reset_i;
    logic        cpu_req_i;
    logic        cpu_we_i;
    cache_addr_t cpu_addr_i;
    cache_word_t cpu_wdata_i;
    logic        cpu_ack_o;
    logic        cpu_hit_o;
    cache_word_t cpu_rdata_o;
    logic        mem_req_o;
    logic        mem_we_o;
    cache_addr_t mem_addr_o;
    cache_word_t mem_wdata_o;
    logic        mem_ack_i;
    cache_word_t mem_rdata_i;

    int seed = 32'h7625;
    int errors;
    int timeouts;
    int checks;
    int mem_txns;
    int mem_writes;
    int mem_delay;

    // memory model contents and the golden copy
    cache_word_t mem_store [cache_addr_t];
    cache_word_t gold_mem [cache_addr_t];
    logic        gold_valid [2][8];
    cache_tag_t  gold_tag [2][8];
    logic        gold_repl [8];

    cache_tb_clock cache_tb_clock_i (.clk(clk), .reset_i(reset_i));

    two_way_cache_top two_way_cache_top_i (.*);

    // memory slave, delay of 1 to 4 cycles before each ack
    always @(posedge clk) begin
        #2;
        if (reset_i) begin
            mem_ack_i <= 1'b0;
            mem_delay <= 0;
        end else if (mem_ack_i) begin
            if (!mem_req_o) mem_ack_i <= 1'b0;
        end else if (mem_req_o) begin
            if (mem_delay == 0) begin
                mem_delay <= int'($unsigned($random(seed)) % 4) + 1;
            end else if (mem_delay == 1) begin
                mem_delay <= 0;
                mem_ack_i <= 1'b1;
                mem_txns  <= mem_txns + 1;
                if (mem_we_o) begin
                    mem_store[mem_addr_o] = mem_wdata_o;
                    mem_writes <= mem_writes + 1;
                end else if (mem_store.exists(mem_addr_o)) begin
                    mem_rdata_i <= mem_store[mem_addr_o];
                end else begin
                    mem_rdata_i <= mem_addr_o ^ MEM_PATTERN;
                end
            end else begin
                mem_delay <= mem_delay - 1;
            end
        end
    end

    function automatic cache_word_t expected_word(input cache_addr_t addr);
        cache_addr_t aligned;
        aligned = {addr[31:2], 2'b00};
        if (gold_mem.exists(aligned)) return gold_mem[aligned];
        return aligned ^ MEM_PATTERN;
    endfunction

    function automatic cache_addr_t make_addr(input cache_tag_t tag, input cache_set_t set);
        return {tag, set, 2'b00};
    endfunction

    task automatic report_and_finish();
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
        timeouts++;
        report_and_finish();
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    // one four-phase transaction, checked against the golden model
    task automatic cpu_access(input string name, input logic we, input cache_addr_t addr,
                              input cache_word_t wdata, input int hold);
        cache_tag_t  tag;
        cache_set_t  set;
        logic        exp_hit;
        logic        way;
        cache_word_t exp_data;
        int          txns_before;
        int          writes_before;
        int          cycles;
        tag = addr[31:5];
        set = addr[4:2];
        exp_hit = (gold_valid[0][set] && gold_tag[0][set] == tag) ||
                  (gold_valid[1][set] && gold_tag[1][set] == tag);
        exp_data = we ? wdata : expected_word(addr);
        // idle gap so decode is free again
        repeat (2) @(posedge clk);
        #2;
        txns_before   = mem_txns;
        writes_before = mem_writes;
        cpu_req_i   = 1'b1;
        cpu_we_i    = we;
        cpu_addr_i  = addr;
        cpu_wdata_i = wdata;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) give_up({name, " acknowledge rise"});
        end while (!cpu_ack_o);
        compare({name, " hit"}, {31'd0, exp_hit}, {31'd0, cpu_hit_o});
        compare({name, " data"}, exp_data, cpu_rdata_o);
        compare({name, " memory txns"}, (!we && exp_hit) ? 0 : 1, mem_txns - txns_before);
        compare({name, " memory writes"}, we ? 1 : 0, mem_writes - writes_before);
        if (!we && exp_hit) compare({name, " hit latency"}, 3, cycles);
        repeat (hold) @(posedge clk);
        @(posedge clk);
        #2;
        cpu_req_i = 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) give_up({name, " acknowledge fall"});
        end while (cpu_ack_o);
        // golden update: write-through no-allocate, fill invalid way first
        if (we) begin
            gold_mem[{addr[31:2], 2'b00}] = wdata;
        end else if (!exp_hit) begin
            if (!gold_valid[0][set]) way = 1'b0;
            else if (!gold_valid[1][set]) way = 1'b1;
            else way = gold_repl[set];
            gold_valid[way][set] = 1'b1;
            gold_tag[way][set] = tag;
            gold_repl[set] = ~way;
        end
    endtask

    initial begin
        int cycles;
        cache_addr_t addr;
        cpu_req_i   = 1'b0;
        cpu_we_i    = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        mem_txns    = 0;
        mem_writes  = 0;
        mem_delay   = 0;
        for (int s = 0; s < 8; s++) begin
            gold_valid[0][s] = 1'b0;
            gold_valid[1][s] = 1'b0;
            gold_repl[s] = 1'b0;
        end
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) give_up("reset release");
        end while (reset_i);
        #1;
        compare("reset ack", 0, {31'd0, cpu_ack_o});
        compare("reset mem req", 0, {31'd0, mem_req_o});

        cpu_access("first read", 1'b0, make_addr(27'h10, 3'd1), '0, 0);
        cpu_access("repeat read", 1'b0, make_addr(27'h10, 3'd1), '0, 0);

        // tags A, B, C share set 3
        cpu_access("evict A", 1'b0, make_addr(27'h0a, 3'd3), '0, 0);
        cpu_access("evict B", 1'b0, make_addr(27'h0b, 3'd3), '0, 0);
        cpu_access("evict C", 1'b0, make_addr(27'h0c, 3'd3), '0, 1);
        cpu_access("evict B again", 1'b0, make_addr(27'h0b, 3'd3), '0, 0);
        cpu_access("evict A again", 1'b0, make_addr(27'h0a, 3'd3), '0, 0);

        cpu_access("write hit", 1'b1, make_addr(27'h10, 3'd1), 32'hdead_beef, 0);
        cpu_access("read after write hit", 1'b0, make_addr(27'h10, 3'd1), '0, 0);
        cpu_access("write miss", 1'b1, make_addr(27'h22, 3'd5), 32'h1234_5678, 2);
        cpu_access("read after write miss", 1'b0, make_addr(27'h22, 3'd5), '0, 0);

        // random mix over a few tags and two sets, some held requests
        for (int i = 0; i < 24; i++) begin
            addr = make_addr(cache_tag_t'($unsigned($random(seed)) % 4),
                             cache_set_t'($unsigned($random(seed)) % 2));
            // byte offset varies, the cache ignores it
            addr[1:0] = 2'($unsigned($random(seed)) % 4);
            cpu_access("random", ($unsigned($random(seed)) % 4) == 0, addr,
                       $random(seed), int'($unsigned($random(seed)) % 3));
        end

        report_and_finish();
    end

endmodule

// ==== verification/cache_tb_clock.sv ====
// free running clock and power-on reset for the cache testbench
module cache_tb_clock (
    output logic clk,
    output logic reset_i
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // held for ten rising edges, released just after the last one
    initial begin
        reset_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset_i = 1'b0;
    end

endmodule
